//--- verilog/sha_acc_pkg.sv
/*
 * SHA-256 accelerator shared definitions
 * Memory map, status codes, width types, round constants and initial hash
 */
package sha_acc_pkg;

    // ==============================
    // Width types
    // ==============================
    typedef logic [15:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [511:0] block_t;
    typedef logic [255:0] digest_t;
    typedef logic [6:0]   round_t;
    typedef logic [1:0]   stage_t;

    // Compression stages
    localparam stage_t STAGE_BLOCK1 = 2'd0;
    localparam stage_t STAGE_BLOCK2 = 2'd1;
    localparam stage_t STAGE_REHASH = 2'd2;

    // ==============================
    // Memory map and status codes
    // ==============================
    localparam addr_t ACB_BASE        = 16'h5000;
    localparam addr_t ACB_DIGEST_ADDR = 16'h5008;
    localparam addr_t HCB_BLOCK1_ADDR = 16'h1000;
    localparam addr_t HCB_BLOCK2_ADDR = 16'h1040;

    localparam int    STATUS_START_BIT = 0;
    localparam word_t STATUS_BUSY      = 32'd5;
    localparam word_t STATUS_DONE      = 32'd2;

    // ==============================
    // SHA-256 constants
    // ==============================
    localparam round_t HASH_ROUNDS = 7'd64;

    // Padding of the 256-bit rehash block
    localparam word_t REHASH_PAD = 32'h8000_0000;
    localparam word_t REHASH_LEN = 32'd256;

    localparam word_t SHA_K [64] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // Initial hash words H0 to H7
    localparam word_t SHA_IV [8] = '{
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    // Rotate right, used by both sigma families
    function automatic word_t rotr(input word_t x, input int unsigned n);
        rotr = (x >> n) | (x << (32 - n));
    endfunction

endpackage

//--- verilog/acc_control_unit.sv
/*
 * Accelerator control unit
 * Watches the status write, sequences both block reads, three chained
 * compressions and the status and digest write-back
 */
module acc_control_unit import sha_acc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    // Host status write monitor
    input  logic    listen_en,
    input  addr_t   listen_addr,
    input  word_t   listen_data,

    // Memory responses
    input  logic    read_valid,
    input  logic    write_done,

    // Chaining registers from the compressor
    input  digest_t digest,

    // Memory requests
    output logic    read_en,
    output addr_t   read_addr,
    output logic    write_en,
    output addr_t   write_addr,
    output word_t   write_data,

    // Scheduler control
    output logic    ms_init,
    output logic    ms_enable,
    output stage_t  msg_sel,
    output logic    save_hash,

    // Compressor control
    output logic    cm_load_iv,
    output logic    cm_update_a_h,
    output logic    cm_hashing,
    output logic    cm_update_h,
    output round_t  round
);

    // ==============================
    // States
    // ==============================
    typedef enum logic [3:0] {
        S_IDLE,
        S_READ_BLK1,     // Fetch first header block
        S_WRITE_BUSY,    // Busy status to the ACB
        S_IV_INIT,       // Chaining registers from IV
        S_UPD_AH,        // Round setup, A..H from H0..H7
        S_HASH,          // 64 rounds
        S_UPD_H,         // Final addition
        S_STAGE_DECIDE,  // Next block, rehash or write-back
        S_READ_BLK2,     // Fetch second header block
        S_WRITE_DIGEST,  // H0..H7, one word per grant
        S_WRITE_DONE     // Done status to the ACB
    } state_t;

    state_t state, next_state;

    stage_t          stage_q;
    logic   [2:0]    word_q;

    // Counter strobes from the FSM
    logic            round_clr;
    logic            round_inc;
    logic            stage_inc;
    logic            stage_clr;
    logic            word_inc;
    logic            word_clr;

    logic            start_req;

    // Host writes the start bit into the status word
    assign start_req = listen_en && (listen_addr == ACB_BASE)
                       && listen_data[STATUS_START_BIT];

    assign msg_sel = stage_q;

    // ==============================
    // Next state and outputs
    // ==============================
    always_comb begin
        next_state    = state;

        read_en       = 1'b0;
        read_addr     = '0;
        write_en      = 1'b0;
        write_addr    = '0;
        write_data    = '0;

        ms_init       = 1'b0;
        ms_enable     = 1'b0;
        save_hash     = 1'b0;
        cm_load_iv    = 1'b0;
        cm_update_a_h = 1'b0;
        cm_hashing    = 1'b0;
        cm_update_h   = 1'b0;

        round_clr     = 1'b0;
        round_inc     = 1'b0;
        stage_inc     = 1'b0;
        stage_clr     = 1'b0;
        word_inc      = 1'b0;
        word_clr      = 1'b0;

        case (state)
            S_IDLE: begin
                // Starts are only seen here, so a busy job ignores them
                if (start_req) begin
                    next_state = S_READ_BLK1;
                end
            end

            S_READ_BLK1: begin
                read_en   = 1'b1;
                read_addr = HCB_BLOCK1_ADDR;
                if (read_valid) begin
                    next_state = S_WRITE_BUSY;
                end
            end

            S_WRITE_BUSY: begin
                write_en   = 1'b1;
                write_addr = ACB_BASE;
                write_data = STATUS_BUSY;
                if (write_done) begin
                    next_state = S_IV_INIT;
                end
            end

            S_IV_INIT: begin
                cm_load_iv = 1'b1;
                next_state = S_UPD_AH;
            end

            S_UPD_AH: begin
                // Window load and working register copy in one cycle
                cm_update_a_h = 1'b1;
                ms_init       = 1'b1;
                round_clr     = 1'b1;
                next_state    = S_HASH;
            end

            S_HASH: begin
                cm_hashing = 1'b1;
                ms_enable  = 1'b1;
                round_inc  = 1'b1;
                if (round == HASH_ROUNDS - 7'd1) begin
                    next_state = S_UPD_H;
                end
            end

            S_UPD_H: begin
                cm_update_h = 1'b1;
                next_state  = S_STAGE_DECIDE;
            end

            S_STAGE_DECIDE: begin
                case (stage_q)
                    STAGE_BLOCK1: begin
                        // Stage 1 chains on, no IV reload
                        stage_inc  = 1'b1;
                        next_state = S_READ_BLK2;
                    end
                    STAGE_BLOCK2: begin
                        // Header hash becomes the rehash message
                        save_hash  = 1'b1;
                        stage_inc  = 1'b1;
                        next_state = S_IV_INIT;
                    end
                    default: begin
                        stage_clr  = 1'b1;
                        next_state = S_WRITE_DIGEST;
                    end
                endcase
            end

            S_READ_BLK2: begin
                read_en   = 1'b1;
                read_addr = HCB_BLOCK2_ADDR;
                if (read_valid) begin
                    next_state = S_UPD_AH;
                end
            end

            S_WRITE_DIGEST: begin
                write_en   = 1'b1;
                write_addr = ACB_DIGEST_ADDR + addr_t'({word_q, 2'b00});
                write_data = digest[32*word_q +: 32];
                if (write_done) begin
                    if (word_q == 3'd7) begin
                        word_clr   = 1'b1;
                        next_state = S_WRITE_DONE;
                    end else begin
                        word_inc = 1'b1;
                    end
                end
            end

            S_WRITE_DONE: begin
                write_en   = 1'b1;
                write_addr = ACB_BASE;
                write_data = STATUS_DONE;
                if (write_done) begin
                    next_state = S_IDLE;
                end
            end

            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    // ==============================
    // State and counters
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Round counter ends at 64 after the last hashing cycle
    always_ff @(posedge clk) begin
        if (!rst_n || round_clr) begin
            round <= '0;
        end else if (round_inc) begin
            round <= round + 7'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || stage_clr) begin
            stage_q <= STAGE_BLOCK1;
        end else if (stage_inc) begin
            stage_q <= stage_q + 2'd1;
        end
    end

    // Digest word index for the write-back
    always_ff @(posedge clk) begin
        if (!rst_n || word_clr) begin
            word_q <= '0;
        end else if (word_inc) begin
            word_q <= word_q + 3'd1;
        end
    end

endmodule

//--- verilog/msg_scheduler.sv
/*
 * SHA-256 message scheduler
 * Holds the fetched block and saved digest, builds the padded rehash block
 * and produces one schedule word per round from a 16-word window
 */
module msg_scheduler import sha_acc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    read_valid,
    input  block_t  read_data,
    input  digest_t digest,
    input  logic    save_hash,
    input  stage_t  msg_sel,
    input  logic    ms_init,
    input  logic    ms_enable,
    output word_t   w
);

    block_t  blk_q;
    digest_t saved_q;
    word_t   win [16];
    word_t   init_win [16];
    word_t   w_next;

    // Small sigma functions of the schedule
    function automatic word_t sig0(input word_t x);
        sig0 = rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic word_t sig1(input word_t x);
        sig1 = rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

    // Last line from memory, and the header hash for the rehash
    always_ff @(posedge clk) begin
        if (read_valid) begin
            blk_q <= read_data;
        end
        if (save_hash) begin
            saved_q <= digest;
        end
    end

    // ==============================
    // Window source
    // ==============================
    always_comb begin
        // Word 0 sits at the top of the line
        for (int i = 0; i < 16; i++) begin
            init_win[i] = blk_q[511 - 32*i -: 32];
        end
        if (msg_sel == STAGE_REHASH) begin
            for (int i = 0; i < 8; i++) begin
                init_win[i] = saved_q[32*i +: 32];
            end
            init_win[8] = REHASH_PAD;
            for (int i = 9; i < 15; i++) begin
                init_win[i] = '0;
            end
            init_win[15] = REHASH_LEN;
        end
    end

    // W[t] from W[t-2], W[t-7], W[t-15] and W[t-16]
    assign w_next = sig1(win[14]) + win[9] + sig0(win[1]) + win[0];
    assign w      = win[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                win[i] <= '0;
            end
        end else if (ms_init) begin
            win <= init_win;
        end else if (ms_enable) begin
            for (int i = 0; i < 15; i++) begin
                win[i] <= win[i + 1];
            end
            win[15] <= w_next;
        end
    end

endmodule

//--- verilog/hash_compressor.sv
/*
 * SHA-256 round compressor
 * Working registers A..H, chaining registers H0..H7, one round per cycle
 */
module hash_compressor import sha_acc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cm_load_iv,
    input  logic    cm_update_a_h,
    input  logic    cm_hashing,
    input  logic    cm_update_h,
    input  round_t  round,
    input  word_t   w,
    output digest_t digest
);

    // Chaining registers H0..H7
    word_t hv [8];

    // Working registers
    word_t a_r;
    word_t b_r;
    word_t c_r;
    word_t d_r;
    word_t e_r;
    word_t f_r;
    word_t g_r;
    word_t h_r;

    word_t t1;
    word_t t2;

    // ==============================
    // Round function
    // ==============================
    function automatic word_t big_sig0(input word_t x);
        big_sig0 = rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
    endfunction

    function automatic word_t big_sig1(input word_t x);
        big_sig1 = rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
    endfunction

    // Ch and Maj folded into the two temporaries
    assign t1 = h_r + big_sig1(e_r) + ((e_r & f_r) ^ (~e_r & g_r))
                + SHA_K[round[5:0]] + w;
    assign t2 = big_sig0(a_r) + ((a_r & b_r) ^ (a_r & c_r) ^ (b_r & c_r));

    always_ff @(posedge clk) begin
        if (cm_update_a_h) begin
            a_r <= hv[0];
            b_r <= hv[1];
            c_r <= hv[2];
            d_r <= hv[3];
            e_r <= hv[4];
            f_r <= hv[5];
            g_r <= hv[6];
            h_r <= hv[7];
        end else if (cm_hashing) begin
            a_r <= t1 + t2;
            b_r <= a_r;
            c_r <= b_r;
            d_r <= c_r;
            e_r <= d_r + t1;
            f_r <= e_r;
            g_r <= f_r;
            h_r <= g_r;
        end
    end

    // ==============================
    // Chaining and final addition
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n || cm_load_iv) begin
            for (int i = 0; i < 8; i++) begin
                hv[i] <= SHA_IV[i];
            end
        end else if (cm_update_h) begin
            hv[0] <= hv[0] + a_r;
            hv[1] <= hv[1] + b_r;
            hv[2] <= hv[2] + c_r;
            hv[3] <= hv[3] + d_r;
            hv[4] <= hv[4] + e_r;
            hv[5] <= hv[5] + f_r;
            hv[6] <= hv[6] + g_r;
            hv[7] <= hv[7] + h_r;
        end
    end

    // H0 in the low word
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            digest[32*i +: 32] = hv[i];
        end
    end

endmodule

//--- verilog/sha_accelerator.sv
/*
 * SHA-256 mining accelerator top level
 * Control unit, message scheduler and compressor on the memory ports
 */
module sha_accelerator import sha_acc_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,

    // Host status write monitor
    input  logic   listen_en,
    input  addr_t  listen_addr,
    input  word_t  listen_data,

    // Read port
    output logic   read_en,
    output addr_t  read_addr,
    input  logic   read_valid,
    input  block_t read_data,

    // Write port
    output logic   write_en,
    output addr_t  write_addr,
    output word_t  write_data,
    input  logic   write_done
);

    // Control strobes
    logic    ms_init;
    logic    ms_enable;
    stage_t  msg_sel;
    logic    save_hash;
    logic    cm_load_iv;
    logic    cm_update_a_h;
    logic    cm_hashing;
    logic    cm_update_h;
    round_t  round;

    // Datapath
    digest_t digest;
    word_t   w;

    acc_control_unit u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .listen_en     (listen_en),
        .listen_addr   (listen_addr),
        .listen_data   (listen_data),
        .read_valid    (read_valid),
        .write_done    (write_done),
        .digest        (digest),
        .read_en       (read_en),
        .read_addr     (read_addr),
        .write_en      (write_en),
        .write_addr    (write_addr),
        .write_data    (write_data),
        .ms_init       (ms_init),
        .ms_enable     (ms_enable),
        .msg_sel       (msg_sel),
        .save_hash     (save_hash),
        .cm_load_iv    (cm_load_iv),
        .cm_update_a_h (cm_update_a_h),
        .cm_hashing    (cm_hashing),
        .cm_update_h   (cm_update_h),
        .round         (round)
    );

    // Block register loads on every read grant
    msg_scheduler u_sched (
        .clk        (clk),
        .rst_n      (rst_n),
        .read_valid (read_valid),
        .read_data  (read_data),
        .digest     (digest),
        .save_hash  (save_hash),
        .msg_sel    (msg_sel),
        .ms_init    (ms_init),
        .ms_enable  (ms_enable),
        .w          (w)
    );

    hash_compressor u_comp (
        .clk           (clk),
        .rst_n         (rst_n),
        .cm_load_iv    (cm_load_iv),
        .cm_update_a_h (cm_update_a_h),
        .cm_hashing    (cm_hashing),
        .cm_update_h   (cm_update_h),
        .round         (round),
        .w             (w),
        .digest        (digest)
    );

endmodule

//--- dv/sha_acc_sva.sv
/*
 * Memory port checks for the SHA-256 accelerator
 * Held requests and exclusive read and write
 */
module sha_acc_sva import sha_acc_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  read_en,
    input addr_t read_addr,
    input logic  read_valid,
    input logic  write_en,
    input addr_t write_addr,
    input word_t write_data,
    input logic  write_done
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read request held stable until read_valid
    read_hold: assert property (@(posedge clk) disable iff (!rst_n)
        read_en && !read_valid |=> read_en && $stable(read_addr))
        else $error("read request changed before read_valid");

    // Each read is a single line, so the request drops after the grant
    read_drop: assert property (@(posedge clk) disable iff (!rst_n)
        read_valid |=> !read_en)
        else $error("read request still high after read_valid");

    write_hold: assert property (@(posedge clk) disable iff (!rst_n)
        write_en && !write_done |=> write_en && $stable(write_addr) && $stable(write_data))
        else $error("write request changed before write_done");

    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_en && write_en))
        else $error("read_en and write_en high together");

endmodule

bind sha_accelerator sha_acc_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .read_en    (read_en),
    .read_addr  (read_addr),
    .read_valid (read_valid),
    .write_en   (write_en),
    .write_addr (write_addr),
    .write_data (write_data),
    .write_done (write_done)
);

//--- dv/sha_acc_tb.sv
/*
 * SHA-256 accelerator testbench
 * Random-latency memory model, double SHA-256 reference model, random headers
 */
module sha_acc_tb import sha_acc_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic   clk;
    logic   rst_n;
    logic   listen_en;
    addr_t  listen_addr;
    word_t  listen_data;
    logic   read_en;
    addr_t  read_addr;
    logic   read_valid = 1'b0;
    block_t read_data = '0;
    logic   write_en;
    addr_t  write_addr;
    word_t  write_data;
    logic   write_done = 1'b0;

    // Sparse memory and request logs of the current job
    block_t blk_mem [addr_t];
    word_t  acb_mem [addr_t];
    addr_t  rd_log [$];
    addr_t  wr_addr_log [$];
    word_t  wr_data_log [$];

    integer seed = 37;
    int     rd_wait = 0;
    int     wr_wait = 0;
    int     done_jobs = 0;
    int     accepted = 0;
    int     test_err = 0;
    int     tests = 0;
    int     failed = 0;
    int     errors = 0;

    sha_accelerator uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .listen_en   (listen_en),
        .listen_addr (listen_addr),
        .listen_data (listen_data),
        .read_en     (read_en),
        .read_addr   (read_addr),
        .read_valid  (read_valid),
        .read_data   (read_data),
        .write_en    (write_en),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .write_done  (write_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // Memory model
    // ==============================
    // Each held request is answered after 0 to 5 cycles with a one-cycle pulse
    always @(negedge clk) begin
        read_valid <= 1'b0;
        write_done <= 1'b0;
        if (rst_n && read_en) begin
            if (rd_wait == 0) begin
                read_valid <= 1'b1;
                read_data  <= blk_mem.exists(read_addr) ? blk_mem[read_addr] : '0;
                rd_log.push_back(read_addr);
                rd_wait = $unsigned($random(seed)) % 6;
            end else begin
                rd_wait--;
            end
        end
        if (rst_n && write_en) begin
            if (wr_wait == 0) begin
                write_done <= 1'b1;
                acb_mem[write_addr] = write_data;
                wr_addr_log.push_back(write_addr);
                wr_data_log.push_back(write_data);
                // Done status closes a job
                if (write_addr == ACB_BASE && write_data == STATUS_DONE) begin
                    done_jobs++;
                end
                wr_wait = $unsigned($random(seed)) % 6;
            end else begin
                wr_wait--;
            end
        end
    end

    // ==============================
    // Reference model
    // ==============================
    function automatic word_t rotate_right(input word_t x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    // One SHA-256 compression with state word i at bits 32i+31:32i
    function automatic digest_t compress_block(input digest_t st, input block_t blk);
        word_t   m [64];
        word_t   v [8];
        word_t   t1;
        word_t   t2;
        digest_t res;
        for (int t = 0; t < 16; t++) begin
            m[t] = blk[511 - 32*t -: 32];
        end
        for (int t = 16; t < 64; t++) begin
            m[t] = (rotate_right(m[t-2], 17) ^ rotate_right(m[t-2], 19) ^ (m[t-2] >> 10))
                 + m[t-7] + m[t-16]
                 + (rotate_right(m[t-15], 7) ^ rotate_right(m[t-15], 18) ^ (m[t-15] >> 3));
        end
        for (int i = 0; i < 8; i++) begin
            v[i] = st[32*i +: 32];
        end
        for (int t = 0; t < 64; t++) begin
            t1 = v[7] + (rotate_right(v[4], 6) ^ rotate_right(v[4], 11) ^ rotate_right(v[4], 25))
               + ((v[4] & v[5]) ^ (~v[4] & v[6])) + SHA_K[t] + m[t];
            t2 = (rotate_right(v[0], 2) ^ rotate_right(v[0], 13) ^ rotate_right(v[0], 22))
               + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
            for (int i = 7; i > 0; i--) begin
                v[i] = v[i-1];
            end
            v[4] = v[4] + t1;
            v[0] = t1 + t2;
        end
        for (int i = 0; i < 8; i++) begin
            res[32*i +: 32] = st[32*i +: 32] + v[i];
        end
        return res;
    endfunction

    // Header hash over both blocks, then the hash of that digest
    function automatic digest_t double_sha256(input block_t b1, input block_t b2);
        digest_t iv;
        digest_t h;
        block_t  b3;
        for (int i = 0; i < 8; i++) begin
            iv[32*i +: 32] = SHA_IV[i];
        end
        h  = compress_block(compress_block(iv, b1), b2);
        b3 = '0;
        for (int i = 0; i < 8; i++) begin
            b3[511 - 32*i -: 32] = h[32*i +: 32];
        end
        b3[255 -: 32] = 32'h8000_0000;
        b3[31:0]      = 32'd256;
        return compress_block(iv, b3);
    endfunction

    // ==============================
    // Checks and waits
    // ==============================
    task automatic report_failure(input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        test_err++;
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
            test_err++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
            test_err++;
        end
    endtask

    task automatic check_digest(input string name, input digest_t exp, input digest_t act);
        if (exp !== act) begin
            $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
            test_err++;
        end
    endtask

    // One-cycle status write seen by the listen port
    task automatic send_listen(input addr_t addr, input word_t data);
        @(negedge clk);
        listen_en   = 1'b1;
        listen_addr = addr;
        listen_data = data;
        @(negedge clk);
        listen_en   = 1'b0;
    endtask

    task automatic wait_writes(input int n, input int limit);
        int cnt;
        cnt = 0;
        while (wr_addr_log.size() < n && cnt < limit) begin
            @(posedge clk);
            cnt++;
        end
        if (wr_addr_log.size() < n) begin
            report_failure($sformatf("timeout after %0d cycles waiting for %0d writes", limit, n));
        end
    endtask

    task automatic wait_first_read(input int limit);
        int cnt;
        cnt = 0;
        while (rd_log.size() == 0 && cnt < limit) begin
            @(posedge clk);
            cnt++;
        end
        if (rd_log.size() == 0) begin
            report_failure("timeout waiting for the first block read");
        end
    endtask

    task automatic expect_no_read(input int cycles);
        int seen;
        seen = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (read_en) begin
                seen = 1;
            end
        end
        if (seen) begin
            report_failure("read_en rose without an accepted start");
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %s", name, test_err == 0 ? "ok" : "failed");
        tests++;
        errors += test_err;
        if (test_err != 0) begin
            failed++;
        end
        test_err = 0;
    endtask

    // ==============================
    // One job on a random header
    // ==============================
    task automatic run_job(input bit second_start);
        block_t  b1;
        block_t  b2;
        digest_t got;
        b2 = '0;
        for (int i = 0; i < 16; i++) begin
            b1[511 - 32*i -: 32] = $random(seed);
        end
        // Last 16 header bytes, padding bit and 640-bit length
        for (int i = 0; i < 4; i++) begin
            b2[511 - 32*i -: 32] = $random(seed);
        end
        b2[383 -: 32] = 32'h8000_0000;
        b2[31:0]      = 32'd640;
        blk_mem[HCB_BLOCK1_ADDR] = b1;
        blk_mem[HCB_BLOCK2_ADDR] = b2;
        rd_log.delete();
        wr_addr_log.delete();
        wr_data_log.delete();
        acb_mem.delete();
        send_listen(ACB_BASE, 32'h1);
        accepted++;
        if (second_start) begin
            wait_first_read(100);
            send_listen(ACB_BASE, 32'h1);
        end
        wait_writes(10, 2000);
        if (rd_log.size() != 2) begin
            report_failure($sformatf("%0d block reads in one job", rd_log.size()));
        end else begin
            check_addr("read_addr", HCB_BLOCK1_ADDR, rd_log[0]);
            check_addr("read_addr", HCB_BLOCK2_ADDR, rd_log[1]);
        end
        if (wr_addr_log.size() != 10) begin
            report_failure($sformatf("%0d writes in one job", wr_addr_log.size()));
        end else begin
            check_addr("write_addr", ACB_BASE, wr_addr_log[0]);
            check_word("write_data", STATUS_BUSY, wr_data_log[0]);
            for (int i = 1; i < 9; i++) begin
                check_addr($sformatf("write_addr H%0d", i - 1),
                           ACB_DIGEST_ADDR + 16'(4 * (i - 1)), wr_addr_log[i]);
                got[32*(i-1) +: 32] = acb_mem[ACB_DIGEST_ADDR + 16'(4 * (i - 1))];
            end
            check_addr("write_addr", ACB_BASE, wr_addr_log[9]);
            check_word("write_data", STATUS_DONE, wr_data_log[9]);
            check_digest("digest", double_sha256(b1, b2), got);
        end
        // A queued second start would show up as a new read here
        if (second_start) begin
            expect_no_read(100);
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        listen_en   = 1'b0;
        listen_addr = '0;
        listen_data = '0;
        rst_n       = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // Wrong address, then start bit clear
        send_listen(16'h5004, 32'h1);
        send_listen(ACB_BASE, 32'h4);
        expect_no_read(100);
        finish_test("start_detect");

        for (int j = 0; j < 10; j++) begin
            run_job(1'b0);
            finish_test($sformatf("digest_%0d", j));
        end

        run_job(1'b1);
        finish_test("busy_ignore");

        if (done_jobs != accepted) begin
            report_failure($sformatf("%0d jobs done for %0d starts", done_jobs, accepted));
        end
        finish_test("job_count");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- sha_accelerator.f
verilog/sha_acc_pkg.sv
verilog/acc_control_unit.sv
verilog/msg_scheduler.sv
verilog/hash_compressor.sv
verilog/sha_accelerator.sv
dv/sha_acc_sva.sv
dv/sha_acc_tb.sv

//--- Makefile
# Verilator build of the SHA-256 accelerator testbench

TOP := sha_acc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
		--top-module $(TOP) -f sha_accelerator.f

# Fails unless the pass message appears in the simulation output
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
